// ==== all.f ====
spiMemPkg.sv
inputConditioner.sv
spiFsm.sv
shiftRegister.sv
dataMemory.sv
spiMemory.sv
spiMemoryTb.sv

// ==== dataMemory.sv ====
// 128 x 8 array with no reset; reads follow the latched address combinationally, writes land on the clk edge.
`timescale 1ns/10ps

module dataMemory (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           addrWe,
    input  logic                           memWe,
    input  logic [spiMemPkg::dataBits-1:0] dataIn,
    output logic [spiMemPkg::dataBits-1:0] readData
);

    logic [spiMemPkg::addrBits-1:0] addrReg;
    logic [spiMemPkg::dataBits-1:0] memArray [spiMemPkg::memDepth];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            addrReg <= '0;
        end else if (addrWe) begin
            addrReg <= dataIn[spiMemPkg::addrBits-1:0]; // low bits hold the address.
        end
    end

    always_ff @(posedge clk) begin
        if (memWe) begin
            memArray[addrReg] <= dataIn;
        end
    end

    assign readData = memArray[addrReg];

    // address latch and write are eight sclk edges apart within a frame.
    addrWriteApart: assert property (
        @(posedge clk) disable iff (!rstN)
        !(memWe && addrWe)
    );

endmodule

// ==== inputConditioner.sv ====
// sclk, csN and mosi are asynchronous; outputs lag the pins by two clk cycles and sclk must stay level for four or more.
`timescale 1ns/10ps

module inputConditioner (
    input  logic clk,
    input  logic rstN,
    input  logic sclk,
    input  logic csN,
    input  logic mosi,
    output logic csLow,
    output logic mosiSync,
    output logic sclkRise,
    output logic sclkFall
);

    // both stages carry {sclk, csN, mosi}.
    logic [2:0] pinMeta;
    logic [2:0] pinSync;
    logic       sclkPrev;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pinMeta  <= 3'b010;                  // deselected, sclk low.
            pinSync  <= 3'b010;
            sclkPrev <= 1'b0;
        end else begin
            pinMeta  <= {sclk, csN, mosi};
            pinSync  <= pinMeta;
            sclkPrev <= pinSync[2];
        end
    end

    assign csLow    = !pinSync[1];
    assign mosiSync = pinSync[0];

    // pulses sit in the cycle where the synced sclk differs from its delayed copy.
    assign sclkRise = pinSync[2] && !sclkPrev;
    assign sclkFall = !pinSync[2] && sclkPrev;

    // sclk stays level for four or more clk cycles, so edge pulses sit at least four apart.
    sclkEdgesApart: assert property (
        @(posedge clk) disable iff (!rstN)
        (sclkRise || sclkFall) |-> !($past(sclkRise || sclkFall, 1)
                                     || $past(sclkRise || sclkFall, 2)
                                     || $past(sclkRise || sclkFall, 3))
    );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the SPI memory testbench with Verilator, runs it and checks for the pass line.
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -sv -f all.f --top-module spiMemoryTb -o simv; then
    echo "verilator build failed"
    exit 1
fi

simOut=$(./obj_dir/simv)
simStatus=$?
echo "$simOut"

if [ "$simStatus" -ne 0 ]; then
    echo "simulation exited with status $simStatus"
    exit 1
fi

if grep -qx "TESTS PASSED" <<< "$simOut"; then
    exit 0
fi
echo "pass line not found in simulation output"
exit 1

// ==== shiftRegister.sv ====
// MSB-first serial register for mode 0; load beats a coinciding shift and serialOut moves only on sclk falls.
`timescale 1ns/10ps

module shiftRegister (
    input  logic                           clk,
    input  logic                           rstN,
    input  logic                           sclkRise,
    input  logic                           sclkFall,
    input  logic                           serialIn,
    input  logic                           load,
    input  logic [spiMemPkg::dataBits-1:0] parallelIn,
    output logic [spiMemPkg::dataBits-1:0] parallelOut,
    output logic                           serialOut
);

    // payload, shifts in MSB first and takes the memory word on a read.
    always_ff @(posedge clk) begin
        if (load) begin
            parallelOut <= parallelIn;
        end else if (sclkRise) begin
            parallelOut <= {parallelOut[spiMemPkg::dataBits-2:0], serialIn};
        end
    end

    // master samples on the rise, so the bit is launched half a period earlier.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            serialOut <= 1'b0;
        end else if (sclkFall) begin
            serialOut <= parallelOut[spiMemPkg::dataBits-1];
        end
    end

endmodule

// ==== spiFsm.sv ====
// mode 0 single-byte frames only; a frame is 7 address bits, 1 rw bit and 8 data bits, and csN high aborts it.
`timescale 1ns/10ps

module spiFsm (
    input  logic               clk,
    input  logic               rstN,
    input  logic               csLow,
    input  logic               sclkRise,
    input  logic               serialIn,
    output logic               addrWe,
    output logic               srLoad,
    output logic               memWe,
    output logic               misoEn,
    output spiMemPkg::fsmState currentState
);

    spiMemPkg::fsmState nextState;
    logic               nextIsRead;

    always_comb begin
        nextState = currentState;
        if (!csLow) begin
            nextState = spiMemPkg::idle;         // abort from anywhere.
        end else begin
            case (currentState) inside
                spiMemPkg::idle: begin
                    nextState = spiMemPkg::addr6;
                end
                [spiMemPkg::addr6 : spiMemPkg::addr0],
                [spiMemPkg::read7 : spiMemPkg::read1],
                [spiMemPkg::write7 : spiMemPkg::write0]: begin
                    if (sclkRise) begin
                        nextState = currentState.next();
                    end
                end
                spiMemPkg::rwBit: begin
                    if (sclkRise) begin
                        nextState = serialIn ? spiMemPkg::read7 : spiMemPkg::write7;
                    end
                end
                spiMemPkg::read0: begin
                    if (sclkRise) begin
                        nextState = spiMemPkg::done;
                    end
                end
                spiMemPkg::writeCommit: begin
                    nextState = spiMemPkg::done;
                end
                spiMemPkg::done: begin
                    nextState = spiMemPkg::done; // waits for csN to rise.
                end
                default: begin
                    nextState = spiMemPkg::idle;
                end
            endcase
        end
    end

    assign nextIsRead = nextState inside {[spiMemPkg::read7 : spiMemPkg::read0]};

    // controls are decoded from the transition so they land one cycle after the sclk edge.
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            currentState <= spiMemPkg::idle;
            addrWe       <= 1'b0;
            srLoad       <= 1'b0;
            memWe        <= 1'b0;
            misoEn       <= 1'b0;
        end else begin
            currentState <= nextState;
            addrWe       <= (currentState == spiMemPkg::addr0) && (nextState == spiMemPkg::rwBit);
            srLoad       <= (currentState == spiMemPkg::rwBit) && (nextState == spiMemPkg::read7);
            memWe        <= (nextState == spiMemPkg::writeCommit);
            misoEn       <= nextIsRead;
        end
    end

    memWeOneCycle: assert property (
        @(posedge clk) disable iff (!rstN)
        memWe |=> !memWe
    );

    // a frame is either a read or a write, never both.
    loadWriteExclusive: assert property (
        @(posedge clk) disable iff (!rstN)
        !(memWe && srLoad)
    );

    misoEnOnlySelected: assert property (
        @(posedge clk) disable iff (!rstN)
        !csLow |=> !misoEn
    );

endmodule

// ==== spiMemPkg.sv ====
// shared sizes and controller states for the SPI memory slave; mode 0 only, one byte per frame.
package spiMemPkg;

    localparam int addrBits = 7;                 // address bits sent ahead of the rw bit.
    localparam int dataBits = 8;                 // memory word and shift register width.
    localparam int memDepth = 1 << addrBits;     // 128 words.

    // the chains rely on declaration order, so each bit state is followed by the next one.
    typedef enum logic [4:0] {
        idle,
        addr6,
        addr5,
        addr4,
        addr3,
        addr2,
        addr1,
        addr0,
        rwBit,                                   // eighth bit, 1 means read.
        read7,
        read6,
        read5,
        read4,
        read3,
        read2,
        read1,
        read0,
        write7,
        write6,
        write5,
        write4,
        write3,
        write2,
        write1,
        write0,
        writeCommit,                             // one clk cycle for the memory write.
        done                                     // parked until csN rises.
    } fsmState;

endpackage

// ==== spiMemory.sv ====
// SPI mode 0 memory slave; miso needs an external tri-state driven by misoEn, sclk half-period of four clk cycles or more.
`timescale 1ns/10ps

module spiMemory (
    input  logic               clk,
    input  logic               rstN,
    input  logic               sclk,
    input  logic               csN,
    input  logic               mosi,
    output logic               miso,
    output logic               misoEn,
    output spiMemPkg::fsmState currentState
);

    logic                           csLow;
    logic                           mosiSync;
    logic                           sclkRise;
    logic                           sclkFall;
    logic                           addrWe;
    logic                           srLoad;
    logic                           memWe;
    logic [spiMemPkg::dataBits-1:0] srData;    // address source and write data.
    logic [spiMemPkg::dataBits-1:0] memData;

    inputConditioner conditioner0 (
        .clk      (clk),
        .rstN     (rstN),
        .sclk     (sclk),
        .csN      (csN),
        .mosi     (mosi),
        .csLow    (csLow),
        .mosiSync (mosiSync),
        .sclkRise (sclkRise),
        .sclkFall (sclkFall)
    );

    spiFsm fsm0 (
        .clk          (clk),
        .rstN         (rstN),
        .csLow        (csLow),
        .sclkRise     (sclkRise),
        .serialIn     (mosiSync),
        .addrWe       (addrWe),
        .srLoad       (srLoad),
        .memWe        (memWe),
        .misoEn       (misoEn),
        .currentState (currentState)
    );

    shiftRegister shiftReg0 (
        .clk         (clk),
        .rstN        (rstN),
        .sclkRise    (sclkRise),
        .sclkFall    (sclkFall),
        .serialIn    (mosiSync),
        .load        (srLoad),
        .parallelIn  (memData),
        .parallelOut (srData),
        .serialOut   (miso)
    );

    dataMemory memory0 (
        .clk      (clk),
        .rstN     (rstN),
        .addrWe   (addrWe),
        .memWe    (memWe),
        .dataIn   (srData),
        .readData (memData)
    );

endmodule

// ==== spiMemoryTb.sv ====
// SPI mode 0 master at a sclk half-period of six clk cycles; only addresses written earlier are read back.
`timescale 1ns/10ps

module spiMemoryTb;

    localparam int clkPeriodNs     = 40;
    localparam int halfCycles      = 6;              // sclk half-period in clk cycles.
    localparam int resetCycles     = 16;
    localparam int numWrites       = 32;
    localparam int numTransactions = 70;             // test 2, writes, read-backs and the abort.
    localparam longint watchdogNs  = longint'(numTransactions) * 20 * 2 * halfCycles * clkPeriodNs
                                     + resetCycles * clkPeriodNs;

    logic               clk;
    logic               rstN;
    logic               sclk;
    logic               csN;
    logic               mosi;
    logic               miso;
    logic               misoEn;
    spiMemPkg::fsmState state;

    logic [spiMemPkg::dataBits-1:0] refMem [spiMemPkg::memDepth];
    bit                             written [spiMemPkg::memDepth];
    int                             checks;
    int                             checkErrors;
    int                             assertErrors;

    spiMemory dut0 (
        .clk          (clk),
        .rstN         (rstN),
        .sclk         (sclk),
        .csN          (csN),
        .mosi         (mosi),
        .miso         (miso),
        .misoEn       (misoEn),
        .currentState (state)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriodNs / 2) clk = ~clk;
    end

    // two sync flops, then one edge to idle, so the state is idle three edges after csN rises.
    csHighReturnsIdle: assert property (
        @(posedge clk) disable iff (!rstN)
        ($past(csN, 3) && !$past(csN, 4)) |-> (state == spiMemPkg::idle) && !misoEn
    ) else begin
        assertErrors++;
        $display("state not idle with misoEn low three cycles after csN rose at %0t ns", $time);
    end

    task automatic waitCycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic checkValue(input string testName, input logic [7:0] expected,
                              input logic [7:0] actual);
        checks++;
        assert (actual === expected) else begin
            checkErrors++;
            $display("FAIL %s: expected 0x%02h, actual 0x%02h", testName, expected, actual);
        end
    endtask

    task automatic checkIdle(input string testName);
        checks++;
        assert (state == spiMemPkg::idle) else begin
            checkErrors++;
            $display("FAIL %s: expected idle, actual %s", testName, state.name());
        end
    endtask

    // frame[15] goes out first; fewer than 16 bits means csN rises mid-frame.
    task automatic spiTransfer(input logic [15:0] frame, input int nBits, input bit isRead,
                               output logic [7:0] readByte);
        bit expectEn;
        int i;
        int waited;
        readByte = '0;
        @(negedge clk);
        csN  = 1'b0;
        mosi = frame[15];
        waitCycles(halfCycles);
        for (i = 0; i < nBits; i++) begin
            expectEn = isRead && (i >= 8);       // data bits of a read only.
            checks++;
            assert (misoEn == expectEn) else begin
                checkErrors++;
                $display("FAIL misoEn bit %0d: expected %0b, actual %0b", i, expectEn, misoEn);
            end
            if (i >= 8) begin
                readByte = {readByte[6:0], miso};
            end
            sclk = 1'b1;
            waitCycles(halfCycles);
            sclk = 1'b0;
            if (i < 15) begin
                mosi = frame[14 - i];
            end
            waitCycles(halfCycles);
        end
        if (nBits == 16) begin
            waited = 0;
            while (state != spiMemPkg::done && waited < 4 * halfCycles) begin
                waitCycles(1);
                waited++;
            end
            if (state != spiMemPkg::done) begin
                checkErrors++;
                $display("frame 0x%04h did not reach the done state in time", frame);
            end
        end
        csN = 1'b1;
        waitCycles(halfCycles);
    endtask

    task automatic writeByte(input logic [6:0] addr, input logic [7:0] data);
        logic [7:0] unused;
        spiTransfer({addr, 1'b0, data}, 16, 1'b0, unused);
        refMem[addr]  = data;
        written[addr] = 1'b1;
    endtask

    task automatic readAndCompare(input string testName, input logic [6:0] addr);
        logic [7:0] got;
        spiTransfer({addr, 1'b1, 8'h00}, 16, 1'b1, got);
        checkValue(testName, refMem[addr], got);
    endtask

    initial begin
        logic [spiMemPkg::addrBits-1:0] addr;
        logic [7:0]                     data;
        logic [7:0]                     got;
        logic [31:0]                    rnd;
        int                             n;
        int                             a;
        sclk         = 1'b0;
        csN          = 1'b1;
        mosi         = 1'b0;
        rstN         = 1'b0;
        checks       = 0;
        checkErrors  = 0;
        assertErrors = 0;
        rnd = $urandom(32'hc12f5fd4);
        repeat (resetCycles) @(negedge clk);
        rstN = 1'b1;

        waitCycles(4);
        checkIdle("reset state");
        checkValue("reset misoEn", 8'h00, {7'b0, misoEn});

        rnd  = $urandom();
        addr = rnd[6:0];
        data = rnd[15:8];
        writeByte(addr, data);
        readAndCompare("write then read", addr);

        for (n = 0; n < numWrites; n++) begin
            rnd  = $urandom();
            addr = rnd[6:0];
            writeByte(addr, rnd[15:8]);
        end
        for (a = 0; a < spiMemPkg::memDepth; a++) begin
            if (written[a]) begin
                readAndCompare($sformatf("many addresses 0x%02h", a), a[6:0]);
            end
        end

        data = ~refMem[addr];                    // last written address, new contents.
        spiTransfer({addr, 1'b0, data}, 12, 1'b0, got);
        checkIdle("aborted write state");
        readAndCompare("aborted write", addr);

        $display("checks %0d, check errors %0d, assertion errors %0d",
                 checks, checkErrors, assertErrors);
        if (checkErrors == 0 && assertErrors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired before the tests finished");
        $display("TESTS FAILED");
        $finish;
    end

endmodule
